// ==== sim.f ====
+incdir+verif
src/mrx_pkg.sv
src/manchester_decoder.sv
src/frame_control.sv
src/octet_collector.sv
src/crc32_check.sv
src/frame_writer.sv
src/mrx_top.sv
verif/mrx_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module mrx_tb -o mrx_sim
./obj_dir/mrx_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log
then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log
then
  exit 1
fi

// ==== verif/mrx_tb_util.svh ====
`ifndef MRX_TB_UTIL_SVH
`define MRX_TB_UTIL_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// next value in 0 .. n-1
function automatic int rand_below(input int n);
  rng_state = xorshift32(rng_state);
  return int'(rng_state % 32'(n));
endfunction

// reflected CRC-32 over one octet, lsb first
function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
  logic [31:0] c;
  int          i;
  c = crc;
  for (i = 0; i < 8; i++)
  begin
    if (c[0] ^ data[i])
    begin
      c = (c >> 1) ^ 32'hEDB8_8320;
    end
    else
    begin
      c = c >> 1;
    end
  end
  return c;
endfunction

// one half bit, length jittered by -1 .. +1 cycle
task automatic drive_half(input logic level);
  int len;
  len = HALF_BIT - 1 + rand_below(3);
  line <= level;
  repeat (len) @(posedge CLK);
endtask

// Manchester bit, the mid-bit edge carries the value
task automatic drive_bit(input logic value);
  drive_half(!value);
  drive_half(value);
endtask

`endif

// ==== verif/mrx_tb.sv ====
module mrx_tb import mrx_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_FRAMES      = 40;
  localparam int MAX_PAYLOAD     = 60;
  localparam int MAX_BITS        = 15 + 2 + (MAX_PAYLOAD + FCS_OCTETS) * 8 + 7;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * (MAX_BITS * 2 * (HALF_BIT + 1) + 200);

  logic       CLK = 1'b0;
  logic       RST;
  logic       line;
  mem_wr_t    wr;
  frame_rpt_t rpt;
  logic       busy;

  logic [31:0] rng_state;
  mem_wr_t     exp_wr_q [$];   // model output, in write order
  frame_rpt_t  exp_rpt_q [$];
  int          reports_seen = 0;
  string       test_name = "reset";

  mrx_top uut (
    .CLK  (CLK),
    .RST  (RST),
    .line (line),
    .wr   (wr),
    .rpt  (rpt),
    .busy (busy)
  );

  `include "mrx_tb_util.svh"

  always #10 CLK = ~CLK;  // 20 ns period

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_wr(input mem_wr_t exp, input mem_wr_t act);
    if (act !== exp)
    begin
      $display("FAIL %s: write expected addr %0d data %08h, actual addr %0d data %08h",
               test_name, exp.addr, exp.data, act.addr, act.data);
      abort_run();
    end
  endtask

  task automatic check_rpt(input frame_rpt_t exp, input frame_rpt_t act);
    if (act !== exp)
    begin
      $display("FAIL %s: report expected good %0b len %0d, actual good %0b len %0d",
               test_name, exp.good, exp.len, act.good, act.len);
      abort_run();
    end
  endtask

  task automatic check_busy(input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAIL %s: busy expected %0b, actual %0b", test_name, exp, act);
      abort_run();
    end
  endtask

  // outputs are registered, so the falling edge sees them settled
  always @(negedge CLK)
  begin
    if (wr.en === 1'b1)
    begin
      if (exp_wr_q.size() == 0)
      begin
        $display("%s: the DUT wrote to memory when no write was due", test_name);
        abort_run();
      end
      else
      begin
        check_wr(exp_wr_q.pop_front(), wr);
      end
    end
    if (rpt.done === 1'b1)
    begin
      if (exp_rpt_q.size() == 0)
      begin
        $display("%s: the DUT reported a frame when none was sent", test_name);
        abort_run();
      end
      else
      begin
        check_rpt(exp_rpt_q.pop_front(), rpt);
        reports_seen++;
      end
    end
  end

  task automatic send_frame(input int idx);
    logic [7:0]  octets [$];
    logic [7:0]  cur;
    logic [31:0] crc;
    logic [31:0] fcs;
    logic [31:0] word;
    mem_wr_t     w;
    frame_rpt_t  r;
    logic        flip;
    logic        b;
    int          n_payload;
    int          n_extra;
    int          pre_len;
    int          pos;
    int          k;
    int          j;

    n_payload = 1 + rand_below(MAX_PAYLOAD);
    flip      = (rand_below(3) == 0);
    n_extra   = (rand_below(3) == 0) ? 1 + rand_below(7) : 0;
    pre_len   = 10 + rand_below(6);
    test_name = $sformatf("frame %0d, %0d octets, flip %0b, extra %0d",
                          idx, n_payload, flip, n_extra);

    crc = 32'hFFFF_FFFF;
    for (k = 0; k < n_payload; k++)
    begin
      cur = 8'(rand_below(256));
      octets.push_back(cur);
      crc = crc32_byte(crc, cur);
    end
    fcs = ~crc;  // inverted, lsb first on the line
    for (k = 0; k < FCS_OCTETS; k++)
    begin
      octets.push_back(fcs[8 * k +: 8]);
    end
    if (flip)
    begin
      pos = rand_below(octets.size() * 8);
      octets[pos / 8] = octets[pos / 8] ^ (8'h01 << (pos % 8));
    end

    // model: words top byte first from address 0, partial word zero filled
    for (k = 0; k < octets.size(); k += 4)
    begin
      word = '0;
      for (j = 0; j < 4; j++)
      begin
        if (k + j < octets.size())
        begin
          word[8 * (3 - j) +: 8] = octets[k + j];
        end
      end
      w.en   = 1'b1;
      w.addr = ADDR_W'(k / 4);
      w.data = word;
      exp_wr_q.push_back(w);
    end
    r.done = 1'b1;
    r.good = !flip && (n_extra == 0);  // extra bits leave a partial octet
    r.len  = LEN_W'(n_payload);
    exp_rpt_q.push_back(r);

    check_busy(1'b0, busy);
    b = !line;  // no edge at the start of the first bit
    for (k = 0; k < pre_len; k++)
    begin
      drive_bit(b);
      b = !b;
    end
    if (b)
    begin
      drive_bit(1'b1);  // last preamble bit was 0
    end
    drive_bit(1'b1);    // second one of the delimiter pair
    for (k = 0; k < octets.size(); k++)
    begin
      cur = octets[k];
      for (j = 0; j < 8; j++)
      begin
        drive_bit(cur[j]);
      end
    end
    check_busy(1'b1, busy);  // frame still in progress
    for (k = 0; k < n_extra; k++)
    begin
      drive_bit(1'(rand_below(2)));
    end
    repeat (IDLE_TIMEOUT + 10) @(posedge CLK);  // line still

    while (reports_seen < idx + 1)
    begin
      @(posedge CLK);
    end
    if (exp_wr_q.size() != 0)
    begin
      $display("%s: %0d expected writes never appeared", test_name, exp_wr_q.size());
      abort_run();
    end
  endtask

  initial
  begin
    int f;
    rng_state = 32'd32;
    line <= 1'b0;
    RST  <= 1'b0;
    repeat (3) @(posedge CLK);
    RST <= 1'b1;
    repeat (5) @(posedge CLK);
    check_busy(1'b0, busy);
    for (f = 0; f < NUM_FRAMES; f++)
    begin
      send_frame(f);
    end
    test_name = "final idle";
    repeat (IDLE_TIMEOUT + 10) @(posedge CLK);  // quiet line after the last frame
    check_busy(1'b0, busy);
    $display("Simulation passed");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: %0d frames did not finish within %0d cycles",
             NUM_FRAMES, WATCHDOG_CYCLES);
    abort_run();
  end

endmodule

// ==== src/mrx_top.sv ====
module mrx_top import mrx_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       line,
  output mem_wr_t    wr,
  output frame_rpt_t rpt,
  output logic       busy
);

  line_bit_t  line_bit;
  frame_bit_t fbit;
  logic       frame_start;
  logic       frame_end;
  octet_t     octet;
  logic       aligned;
  logic       crc_ok;

  manchester_decoder u_decoder (
    .CLK     (CLK),
    .RST     (RST),
    .line    (line),
    .bit_out (line_bit)
  );

  frame_control u_control (
    .CLK         (CLK),
    .RST         (RST),
    .bit_in      (line_bit),
    .fbit        (fbit),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .busy        (busy)
  );

  octet_collector u_collector (
    .CLK         (CLK),
    .RST         (RST),
    .frame_start (frame_start),
    .fbit        (fbit),
    .octet       (octet),
    .aligned     (aligned)
  );

  crc32_check u_crc (
    .CLK         (CLK),
    .RST         (RST),
    .frame_start (frame_start),
    .fbit        (fbit),
    .crc_ok      (crc_ok)
  );

  frame_writer u_writer (
    .CLK         (CLK),
    .RST         (RST),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .octet       (octet),
    .aligned     (aligned),
    .crc_ok      (crc_ok),
    .wr          (wr),
    .rpt         (rpt)
  );

endmodule

// ==== src/frame_writer.sv ====
module frame_writer import mrx_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       frame_start,
  input  logic       frame_end,
  input  octet_t     octet,
  input  logic       aligned,
  input  logic       crc_ok,
  output mem_wr_t    wr,
  output frame_rpt_t rpt
);

  logic [31:0]       word;
  logic [1:0]        lane;      // next byte slot, 0 is top
  logic [ADDR_W-1:0] addr;
  logic [LEN_W-1:0]  len_cnt;   // octets minus FCS
  logic              end_d;

  // word assembly, low bytes cleared on a fresh word
  always_ff @(posedge CLK)
  begin
    if (octet.valid)
    begin
      if (lane == 2'd0)
      begin
        word <= {octet.data, 24'h0};
      end
      else
      begin
        word[8 * (3 - lane) +: 8] <= octet.data;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      lane    <= '0;
      addr    <= '0;
      len_cnt <= LEN_PRESET;
      end_d   <= 1'b0;
      wr.en   <= 1'b0;
      rpt     <= '0;
    end
    else
    begin
      end_d    <= frame_end;
      wr.en    <= 1'b0;
      rpt.done <= end_d;  // two cycles after frame_end

      if (frame_start)
      begin
        lane    <= '0;
        addr    <= '0;
        len_cnt <= LEN_PRESET;
      end
      else if (octet.valid)
      begin
        lane    <= lane + 1'b1;
        len_cnt <= len_cnt + 1'b1;
        if (lane == 2'd3)
        begin
          wr.en   <= 1'b1;
          wr.addr <= addr;
          wr.data <= {word[31:8], octet.data};
          addr    <= addr + 1'b1;
        end
      end
      else if (frame_end)
      begin
        rpt.good <= crc_ok && aligned;
        rpt.len  <= len_cnt;
        if (lane != 2'd0)
        begin
          // flush the partial word
          wr.en   <= 1'b1;
          wr.addr <= addr;
          wr.data <= word;
        end
      end
    end
  end

endmodule

// ==== src/crc32_check.sv ====
module crc32_check import mrx_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       frame_start,
  input  frame_bit_t fbit,
  output logic       crc_ok
);

  logic [31:0] crc;
  logic        feedback;

  assign feedback = crc[0] ^ fbit.value;

  // an intact FCS leaves the fixed residue behind
  assign crc_ok = (crc == CRC_RESIDUE);

  always_ff @(posedge CLK)
  begin
    if (!RST || frame_start)
    begin
      crc <= '1;  // preset all ones
    end
    else if (fbit.valid)
    begin
      if (feedback)
      begin
        crc <= (crc >> 1) ^ CRC_POLY;
      end
      else
      begin
        crc <= crc >> 1;
      end
    end
  end

endmodule

// ==== src/octet_collector.sv ====
module octet_collector import mrx_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       frame_start,
  input  frame_bit_t fbit,
  output octet_t     octet,
  output logic       aligned
);

  logic [7:0] shreg;
  logic [2:0] cnt;        // bits in current octet
  logic       oct_valid;

  assign octet   = '{valid: oct_valid, data: shreg};
  assign aligned = (cnt == 3'd0);

  always_ff @(posedge CLK)
  begin
    if (!RST || frame_start)
    begin
      cnt       <= '0;
      oct_valid <= 1'b0;
    end
    else
    begin
      oct_valid <= fbit.valid && (cnt == 3'd7);  // counter wraps
      if (fbit.valid)
      begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // shift in from the top, lsb first on the line
  always_ff @(posedge CLK)
  begin
    if (fbit.valid)
    begin
      shreg <= {fbit.value, shreg[7:1]};
    end
  end

endmodule

// ==== src/frame_control.sv ====
module frame_control import mrx_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  line_bit_t  bit_in,
  output frame_bit_t fbit,
  output logic       frame_start,
  output logic       frame_end,
  output logic       busy
);

  rx_state_t         state;
  logic [SYNC_W-1:0] sync_cnt;   // alternating bits seen, saturating
  logic              prev_bit;
  logic              sfd_seen;

  // two ones in a row after enough preamble
  assign sfd_seen = bit_in.valid && bit_in.value && prev_bit &&
                    (sync_cnt >= SYNC_W'(SYNC_MIN));

  assign busy = (state == RECEIVE) || (state == FINISH);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state       <= HUNT;
      sync_cnt    <= '0;
      prev_bit    <= 1'b0;
      fbit        <= '0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end
    else
    begin
      fbit.valid  <= 1'b0;
      fbit.value  <= bit_in.value;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;

      if (bit_in.valid)
      begin
        prev_bit <= bit_in.value;
      end

      case (state)
        HUNT:
          if (bit_in.valid)
          begin
            state    <= PREAMBLE;
            sync_cnt <= SYNC_W'(1);
          end
        PREAMBLE:
          if (bit_in.idle)
          begin
            state <= HUNT;  // lost the line before SFD
          end
          else if (sfd_seen)
          begin
            frame_start <= 1'b1;
            state       <= RECEIVE;
          end
          else if (bit_in.valid)
          begin
            if (bit_in.value != prev_bit)
            begin
              if (sync_cnt < SYNC_W'(SYNC_MIN))
              begin
                sync_cnt <= sync_cnt + 1'b1;
              end
            end
            else
            begin
              sync_cnt <= '0;  // repeat breaks the preamble
            end
          end
        RECEIVE:
          if (bit_in.idle)
          begin
            frame_end <= 1'b1;  // high while in FINISH
            state     <= FINISH;
          end
          else
          begin
            fbit.valid <= bit_in.valid;
          end
        FINISH:
          state <= HUNT;
        default:
          state <= HUNT;
      endcase
    end
  end

endmodule

// ==== src/manchester_decoder.sv ====
module manchester_decoder import mrx_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      line,
  output line_bit_t bit_out
);

  logic               sync0;
  logic               sync1;
  logic               level;     // last synchronized level
  logic [TIMER_W-1:0] timer;     // cycles since accepted transition
  logic               edge_seen;
  logic               accept;

  assign edge_seen = sync1 ^ level;

  // saturated timer also lands here, so the first edge after idle locks
  assign accept = edge_seen && (timer >= TIMER_W'(MID_WINDOW));

  always_ff @(posedge CLK)
  begin
    sync0 <= line;
    sync1 <= sync0;
    level <= sync1;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      timer   <= TIMER_W'(IDLE_TIMEOUT);  // start out idle
      bit_out <= '0;
    end
    else
    begin
      bit_out.valid <= accept;
      bit_out.value <= sync1;  // rise gives 1, fall gives 0
      bit_out.idle  <= !accept && (timer == TIMER_W'(IDLE_TIMEOUT - 1));

      if (accept)
      begin
        timer <= '0;
      end
      else if (timer != TIMER_W'(IDLE_TIMEOUT))
      begin
        timer <= timer + 1'b1;
      end
    end
  end

endmodule

// ==== src/mrx_pkg.sv ====
package mrx_pkg;

  // line timing, in CLK cycles
  localparam int HALF_BIT     = 8;
  localparam int MID_WINDOW   = 12;   // earliest mid-bit transition
  localparam int IDLE_TIMEOUT = 24;   // loss of signal
  localparam int SYNC_MIN     = 6;    // preamble bits before SFD

  localparam int TIMER_W = $clog2(IDLE_TIMEOUT + 1);
  localparam int SYNC_W  = $clog2(SYNC_MIN + 1);

  // memory port and length
  localparam int ADDR_W     = 9;
  localparam int LEN_W      = 11;
  localparam int FCS_OCTETS = 4;
  localparam logic [LEN_W-1:0] LEN_PRESET = LEN_W'(-FCS_OCTETS);

  // reflected CRC-32, no final inversion
  localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;
  localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

  typedef struct packed {
    logic valid;   // bit strobe
    logic value;
    logic idle;    // loss of signal pulse
  } line_bit_t;

  typedef struct packed {
    logic valid;
    logic value;
  } frame_bit_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;   // first bit in bit 0
  } octet_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
  } mem_wr_t;

  typedef struct packed {
    logic             done;
    logic             good;
    logic [LEN_W-1:0] len;
  } frame_rpt_t;

  typedef enum logic [1:0] {HUNT, PREAMBLE, RECEIVE, FINISH} rx_state_t;

endpackage
